//--- logic/exe_pkg.sv
// -------------------------------------
// Execute stage shared definitions
// Widths, size codes, group and op enums,
// opcode union, stage record structs
// -------------------------------------
`default_nettype none

package exe_pkg;

   // -------------------------------------
   // Widths
   localparam int xlen    = 32;                    // Integer data word
   localparam int pc_sz   = 32;                    // Program counter
   localparam int gpr_asz = 5;                     // Register address
   localparam int max_gpr = 32;                    // Number of GPRs

   // Access size codes, same as funct3[1:0] of loads and stores
   localparam logic [1:0] sz_byte = 2'b00;
   localparam logic [1:0] sz_half = 2'b01;
   localparam logic [1:0] sz_word = 2'b10;

   // -------------------------------------
   // Enums
   typedef enum logic [2:0]
   {
      alu_instr,
      br_instr,
      ld_instr,
      st_instr,
      sys_instr,                                   // Passes through, no register write
      ill_instr
   } ig_type_e;

   // Keyword clash with and/or/xor, so every ALU op carries a prefix
   typedef enum logic [3:0]
   {
      alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
      alu_xor, alu_srl, alu_sra, alu_or, alu_and
   } alu_op_e;

   typedef enum logic [3:0]
   {
      b_cond,                                      // Bxx, funct3 picks the compare
      b_jal,
      b_jalr
   } br_op_e;                                      // Same width as alu_op_e

   typedef enum logic [1:0] {sel_rs1, sel_rs2, sel_imm, sel_pc} alu_sel_e;

   // One opcode word, the group says which view holds
   typedef union packed
   {
      alu_op_e alu_op;                             // alu_instr
      br_op_e  br_op;                              // br_instr
   } op_u;

   // -------------------------------------
   // Stage records
   typedef struct packed
   {
      logic [pc_sz-1:0]   pc;
      logic [xlen-1:0]    imm;
      logic [2:0]         funct3;
      ig_type_e           ig_type;
      op_u                op;
      logic [gpr_asz-1:0] rd_addr;
      logic [gpr_asz-1:0] rs1_addr;
      logic [gpr_asz-1:0] rs2_addr;
      logic               rd_wr;
      logic               rs1_rd;                  // Instruction reads Rs1
      logic               rs2_rd;
      alu_sel_e           sel_x;
      alu_sel_e           sel_y;
      logic [pc_sz-1:0]   predicted_addr;          // Where fetch went next
   } dec_to_exe_t;

   typedef struct packed
   {
      logic               valid;
      logic               rd_wr;
      logic [gpr_asz-1:0] rd_addr;
      logic [xlen-1:0]    rd_data;
   } fwd_gpr_t;

   typedef struct packed
   {
      logic [pc_sz-1:0] br_pc;                     // Resolved next PC
      logic [pc_sz-1:0] no_br_pc;                  // pc + 4, also the link value
      logic             mis;
   } br_result_t;

   typedef struct packed
   {
      logic [xlen-1:0] ls_addr;
      logic [xlen-1:0] st_data;
      logic [1:0]      size;
      logic            zero_ext;                   // LBU, LHU
      logic            mis;
   } ls_result_t;

   typedef struct packed
   {
      logic [pc_sz-1:0]   pc;
      ig_type_e           ig_type;
      logic               rd_wr;
      logic [gpr_asz-1:0] rd_addr;
      logic [xlen-1:0]    rd_data;
      logic               is_ld;
      logic               is_st;
      logic [xlen-1:0]    ls_addr;
      logic [xlen-1:0]    st_data;
      logic [1:0]         size;
      logic               zero_ext;
      logic               mis;                     // Misaligned target or access
      logic               mispre;                  // Branch went elsewhere than predicted
   } exe_to_mem_t;

endpackage

`default_nettype wire

//--- logic/operand_forward.sv
// -------------------------------------
// Source operand selection for Rs1/Rs2
// MEM forward, then WB forward, then GPR
// -------------------------------------
`default_nettype none

module operand_forward
(
   input  var  exe_pkg::dec_to_exe_t                            dec,
   input  wire logic [exe_pkg::max_gpr-1:0][exe_pkg::xlen-1:0] gpr,
   input  var  exe_pkg::fwd_gpr_t                               fwd_mem,
   input  var  exe_pkg::fwd_gpr_t                               fwd_wb,
   output logic [exe_pkg::xlen-1:0]                             rs1_val,
   output logic [exe_pkg::xlen-1:0]                             rs2_val
);

   // Later stage holds a newer value of register addr
   function automatic logic fwd_hit(input exe_pkg::fwd_gpr_t             fwd,
                                    input logic [exe_pkg::gpr_asz-1:0] addr);
      return fwd.valid & fwd.rd_wr & (fwd.rd_addr == addr) & (addr != '0);
   endfunction

   // Newest stage wins, x0 always comes from the register file
   function automatic logic [exe_pkg::xlen-1:0] src_val
   (
      input logic                      rd,
      input logic [exe_pkg::gpr_asz-1:0] addr,
      input logic [exe_pkg::xlen-1:0]  reg_val,
      input exe_pkg::fwd_gpr_t         mem,
      input exe_pkg::fwd_gpr_t         wb
   );
      logic [exe_pkg::xlen-1:0] val;
      if (rd & fwd_hit(mem, addr))
         val = mem.rd_data;                        // MEM is the most recent
      else if (rd & fwd_hit(wb, addr))
         val = wb.rd_data;
      else
         val = reg_val;                            // gpr[addr]
      return val;
   endfunction

   assign rs1_val = src_val(dec.rs1_rd, dec.rs1_addr, gpr[dec.rs1_addr], fwd_mem, fwd_wb);
   assign rs2_val = src_val(dec.rs2_rd, dec.rs2_addr, gpr[dec.rs2_addr], fwd_mem, fwd_wb);

endmodule

`default_nettype wire

//--- logic/alu_unit.sv
// -------------------------------------
// Integer ALU, RV32I register and
// immediate ops with X/Y source select
// -------------------------------------
`default_nettype none

module alu_unit
(
   input  var  exe_pkg::dec_to_exe_t dec,
   input  wire logic [exe_pkg::xlen-1:0] rs1_val,
   input  wire logic [exe_pkg::xlen-1:0] rs2_val,
   output logic [exe_pkg::xlen-1:0] rd_data
);

   logic [exe_pkg::xlen-1:0] x;                    // First operand
   logic [exe_pkg::xlen-1:0] y;                    // Second operand
   logic [4:0]               shamt;

   always_comb
   begin
      // AUIPC uses the pc as X
      case (dec.sel_x)
         exe_pkg::sel_pc: x = dec.pc;
         default:         x = rs1_val;
      endcase

      case (dec.sel_y)
         exe_pkg::sel_imm: y = dec.imm;            // I-type, LUI, AUIPC
         default:          y = rs2_val;
      endcase

      shamt = y[4:0];                              // Only low five bits shift

      case (dec.op.alu_op)
         exe_pkg::alu_add:  rd_data = x + y;
         exe_pkg::alu_sub:  rd_data = x - y;
         exe_pkg::alu_sll:  rd_data = x << shamt;
         exe_pkg::alu_slt:  rd_data = {{(exe_pkg::xlen-1){1'b0}}, $signed(x) < $signed(y)};
         exe_pkg::alu_sltu: rd_data = {{(exe_pkg::xlen-1){1'b0}}, x < y};
         exe_pkg::alu_xor:  rd_data = x ^ y;
         exe_pkg::alu_srl:  rd_data = x >> shamt;
         exe_pkg::alu_sra:  rd_data = $signed(x) >>> shamt;   // Keeps the sign
         exe_pkg::alu_or:   rd_data = x | y;
         exe_pkg::alu_and:  rd_data = x & y;
         default:           rd_data = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- logic/branch_unit.sv
// -------------------------------------
// Branch and jump unit: condition,
// target, link address, misalignment
// -------------------------------------
`default_nettype none

module branch_unit
(
   input  var  exe_pkg::dec_to_exe_t     dec,
   input  wire logic [exe_pkg::xlen-1:0] rs1_val,
   input  wire logic [exe_pkg::xlen-1:0] rs2_val,
   output exe_pkg::br_result_t           br
);

   logic                      taken;               // Bxx condition holds
   logic [exe_pkg::pc_sz-1:0] no_br;
   logic [exe_pkg::pc_sz-1:0] jalr_sum;
   logic [exe_pkg::pc_sz-1:0] target;

   always_comb
   begin
      // Compare picked by funct3
      case (dec.funct3)
         3'b000:  taken = (rs1_val == rs2_val);                   // BEQ
         3'b001:  taken = (rs1_val != rs2_val);                   // BNE
         3'b100:  taken = ($signed(rs1_val) <  $signed(rs2_val)); // BLT
         3'b101:  taken = ($signed(rs1_val) >= $signed(rs2_val)); // BGE
         3'b110:  taken = (rs1_val <  rs2_val);                   // BLTU
         3'b111:  taken = (rs1_val >= rs2_val);                   // BGEU
         default: taken = 1'b0;
      endcase

      no_br    = dec.pc + exe_pkg::pc_sz'(4);
      jalr_sum = rs1_val + dec.imm;

      case (dec.op.br_op)
         exe_pkg::b_cond: target = taken ? dec.pc + dec.imm : no_br;
         exe_pkg::b_jal:  target = dec.pc + dec.imm;
         exe_pkg::b_jalr: target = {jalr_sum[exe_pkg::pc_sz-1:1], 1'b0};  // Bit 0 cleared
         default:         target = no_br;
      endcase

      br.br_pc    = target;
      br.no_br_pc = no_br;                         // Link value for JAL/JALR
      br.mis      = target[1];                     // No C extension, so 4 byte alignment
   end

endmodule

`default_nettype wire

//--- logic/ls_addr_unit.sv
// -------------------------------------
// Load/store address unit: address,
// size, store data, misalignment
// -------------------------------------
`default_nettype none

module ls_addr_unit
(
   input  var  exe_pkg::dec_to_exe_t     dec,
   input  wire logic [exe_pkg::xlen-1:0] rs1_val,
   input  wire logic [exe_pkg::xlen-1:0] rs2_val,
   output exe_pkg::ls_result_t           ls
);

   logic [exe_pkg::xlen-1:0] addr;

   assign addr = rs1_val + dec.imm;                // Base plus offset

   always_comb
   begin
      ls.ls_addr  = addr;
      ls.st_data  = rs2_val;                       // Stores only, unused by loads
      ls.zero_ext = dec.funct3[2];                 // LBU/LHU

      case (dec.funct3[1:0])
         2'b00:   ls.size = exe_pkg::sz_byte;
         2'b01:   ls.size = exe_pkg::sz_half;
         default: ls.size = exe_pkg::sz_word;
      endcase

      // Halfword needs even address, word needs 4 byte alignment
      case (ls.size)
         exe_pkg::sz_half: ls.mis = addr[0];
         exe_pkg::sz_word: ls.mis = (addr[1:0] != 2'b00);
         default:          ls.mis = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

//--- logic/exe_result_sel.sv
// -------------------------------------
// Result select by instruction group,
// MEM record build and PC reload request
// -------------------------------------
`default_nettype none

module exe_result_sel
(
   input  wire logic                     dec_valid,
   input  var  exe_pkg::dec_to_exe_t     dec,
   input  wire logic [exe_pkg::xlen-1:0] alu_rd_data,
   input  var  exe_pkg::br_result_t      br,
   input  var  exe_pkg::ls_result_t      ls,
   output exe_pkg::exe_to_mem_t          exe_dout,
   output logic                          rld_pc_flag,
   output logic [exe_pkg::pc_sz-1:0]     rld_pc_addr
);

   logic rd_we;                                    // Real write, never to x0

   assign rd_we = dec.rd_wr & (dec.rd_addr != '0);

   always_comb
   begin
      exe_dout    = '0;                            // Every field idles at zero
      rld_pc_flag = 1'b0;
      rld_pc_addr = '0;

      if (dec_valid)
      begin
         exe_dout.pc      = dec.pc;
         exe_dout.ig_type = dec.ig_type;

         case (dec.ig_type)
            exe_pkg::alu_instr:
            begin
               exe_dout.rd_wr   = rd_we;
               exe_dout.rd_addr = dec.rd_addr;
               exe_dout.rd_data = alu_rd_data;
            end

            exe_pkg::br_instr:
            begin
               if (br.mis)
                  exe_dout.mis = 1'b1;             // Trap is taken further down
               else if (br.br_pc != dec.predicted_addr)
               begin
                  exe_dout.mispre = 1'b1;
                  rld_pc_flag     = 1'b1;          // Fetch restarts at the real target
                  rld_pc_addr     = br.br_pc;
               end
               else if (dec.op.br_op != exe_pkg::b_cond)
               begin
                  // Predicted jump, write the return address
                  exe_dout.rd_wr   = rd_we;
                  exe_dout.rd_addr = dec.rd_addr;
                  exe_dout.rd_data = br.no_br_pc;
               end
            end

            exe_pkg::ld_instr:
            begin
               // Load data itself arrives in MEM
               exe_dout.rd_wr    = rd_we;
               exe_dout.rd_addr  = dec.rd_addr;
               exe_dout.is_ld    = 1'b1;
               exe_dout.ls_addr  = ls.ls_addr;
               exe_dout.size     = ls.size;
               exe_dout.zero_ext = ls.zero_ext;
               exe_dout.mis      = ls.mis;
            end

            exe_pkg::st_instr:
            begin
               exe_dout.is_st    = 1'b1;           // Stores never write Rd
               exe_dout.ls_addr  = ls.ls_addr;
               exe_dout.st_data  = ls.st_data;
               exe_dout.size     = ls.size;
               exe_dout.zero_ext = ls.zero_ext;
               exe_dout.mis      = ls.mis;
            end

            default: ;                             // sys/ill keep only pc and group
         endcase
      end
   end

endmodule

`default_nettype wire

//--- logic/exe_pipe_reg.sv
// -------------------------------------
// One-entry pipeline register with full
// flag between execute and memory
// -------------------------------------
`default_nettype none

module exe_pipe_reg
(
   input  wire logic             clk_in,
   input  wire logic             reset,            // Also driven by pipeline flush
   input  wire logic             write,
   input  var  exe_pkg::exe_to_mem_t data_in,
   input  wire logic             read,
   output exe_pkg::exe_to_mem_t  data_out,
   output logic                  full
);

   // Full flag, write wins over read so both in one cycle keeps it set
   always_ff @(posedge clk_in)
   begin
      if (reset)
         full <= 1'b0;
      else if (write)
         full <= 1'b1;
      else if (read)
         full <= 1'b0;                             // Drained with nothing new
   end

   // Payload register
   always_ff @(posedge clk_in)
   begin
      if (write)
         data_out <= data_in;
   end

endmodule

`default_nettype wire

//--- logic/execute.sv
// -------------------------------------
// Execute stage top: DEC/MEM handshake,
// operand forwarding, ALU, branch and
// load/store units, result pipe register
// -------------------------------------
`default_nettype none

module execute
(
   input  wire logic                      clk_in,
   input  wire logic                      reset,
   input  wire logic                      cpu_halt,    // Stop taking new instructions
   input  wire logic                      pipe_flush,  // Drop the held MEM record

   // Decode side
   input  wire logic                      dec_valid,
   output logic                           dec_rdy,
   input  var  exe_pkg::dec_to_exe_t      dec_data,

   // Register file and forwards
   input  wire logic [exe_pkg::max_gpr-1:0][exe_pkg::xlen-1:0] gpr,
   input  var  exe_pkg::fwd_gpr_t         fwd_mem,
   input  var  exe_pkg::fwd_gpr_t         fwd_wb,

   // Memory side
   output logic                           mem_valid,
   input  wire logic                      mem_rdy,
   output exe_pkg::exe_to_mem_t           mem_data,

   // Fetch PC reload, combinational
   output logic                           rld_pc_flag,
   output logic [exe_pkg::pc_sz-1:0]      rld_pc_addr
);

   logic                     xfer_in;              // Decode hands over an instruction
   logic                     xfer_out;             // MEM takes the held record
   logic                     pipe_full;

   logic [exe_pkg::xlen-1:0] rs1_val;
   logic [exe_pkg::xlen-1:0] rs2_val;
   logic [exe_pkg::xlen-1:0] alu_rd_data;
   exe_pkg::br_result_t      br;
   exe_pkg::ls_result_t      ls;
   exe_pkg::exe_to_mem_t     exe_dout;

   // -------------------------------------
   // Handshake
   // Accept when empty or when the held record leaves this cycle
   assign dec_rdy   = !reset & !cpu_halt & (!pipe_full | xfer_out);
   assign xfer_in   = dec_valid & dec_rdy;
   assign xfer_out  = mem_valid & mem_rdy;
   assign mem_valid = pipe_full;

   // -------------------------------------
   // Functional units
   operand_forward u_operand_forward
   (
      .dec(dec_data), .gpr(gpr), .fwd_mem(fwd_mem), .fwd_wb(fwd_wb),
      .rs1_val(rs1_val), .rs2_val(rs2_val)
   );

   alu_unit u_alu_unit
   (
      .dec(dec_data), .rs1_val(rs1_val), .rs2_val(rs2_val), .rd_data(alu_rd_data)
   );

   branch_unit u_branch_unit
   (
      .dec(dec_data), .rs1_val(rs1_val), .rs2_val(rs2_val), .br(br)
   );

   ls_addr_unit u_ls_addr_unit
   (
      .dec(dec_data), .rs1_val(rs1_val), .rs2_val(rs2_val), .ls(ls)
   );

   exe_result_sel u_exe_result_sel
   (
      .dec_valid(dec_valid), .dec(dec_data), .alu_rd_data(alu_rd_data),
      .br(br), .ls(ls), .exe_dout(exe_dout),
      .rld_pc_flag(rld_pc_flag), .rld_pc_addr(rld_pc_addr)
   );

   // -------------------------------------
   // EXE to MEM register, flush empties it
   exe_pipe_reg u_exe_pipe_reg
   (
      .clk_in(clk_in), .reset(reset | pipe_flush),
      .write(xfer_in), .data_in(exe_dout),
      .read(xfer_out), .data_out(mem_data), .full(pipe_full)
   );

endmodule

`default_nettype wire

//--- tb/tb_execute.sv
// ----------------------------------------
// Testbench for the execute stage
// Stim file reader, DUT drive on the falling edge,
// handshake and result checks, timeout and report
// ----------------------------------------
`default_nettype none

module tb_execute;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int rec_w     = 13;                 // Words per stim record
   localparam int max_rec   = 48;
   localparam int max_stall = 3;                  // Upper bound of mem_rdy stall cycles

   logic                                          clk_in;
   logic                                          reset;
   logic                                          cpu_halt;
   logic                                          pipe_flush;
   logic                                          dec_valid;
   logic                                          dec_rdy;
   logic                                          mem_valid;
   logic                                          mem_rdy;
   logic                                          rld_pc_flag;
   logic [exe_pkg::pc_sz-1:0]                     rld_pc_addr;
   exe_pkg::dec_to_exe_t                          dec_data;
   exe_pkg::exe_to_mem_t                          mem_data;
   exe_pkg::fwd_gpr_t                             fwd_mem;
   exe_pkg::fwd_gpr_t                             fwd_wb;
   logic [exe_pkg::max_gpr-1:0][exe_pkg::xlen-1:0] gpr;   // Model register file

   logic [31:0] stim [0:rec_w*max_rec-1];
   int          errors = 0;
   int          tests  = 0;
   int          cycles = 0;
   int          limit  = 100000;                 // Replaced once the stim is counted
   int          n_rec  = 0;

   execute u_execute
   (
      .clk_in(clk_in), .reset(reset), .cpu_halt(cpu_halt), .pipe_flush(pipe_flush),
      .dec_valid(dec_valid), .dec_rdy(dec_rdy), .dec_data(dec_data),
      .gpr(gpr), .fwd_mem(fwd_mem), .fwd_wb(fwd_wb),
      .mem_valid(mem_valid), .mem_rdy(mem_rdy), .mem_data(mem_data),
      .rld_pc_flag(rld_pc_flag), .rld_pc_addr(rld_pc_addr)
   );

   // ----------------------------------------
   // Clock and cycle limit
   initial
   begin
      clk_in = 1'b0;
      forever #20 clk_in = ~clk_in;              // 40 ns period
   end

   always @(posedge clk_in)
   begin
      cycles++;
      if (cycles > limit)
      begin
         $display("timeout: run went past %0d cycles", limit);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   // ----------------------------------------
   // Check helpers
   task automatic check_field(input string test, input string field,
                              input logic [31:0] exp, input logic [31:0] act);
      assert (exp === act)
      else
      begin
         $display("error %s %s expected %h actual %h", test, field, exp, act);
         errors++;
      end
   endtask

   task automatic check_cond(input string test, input string what, input logic ok);
      assert (ok)
      else
      begin
         $display("%s: %s", test, what);
         errors++;
      end
   endtask

   // Decoded fields from one record, called just after a falling edge
   task automatic drive_instr(input int b);
      logic [31:0] ctl;
      logic [31:0] regs;
      ctl                     = stim[b+3];
      regs                    = stim[b+4];
      dec_data.pc             = stim[b+1];
      dec_data.imm            = stim[b+2];
      dec_data.funct3         = ctl[30:28];
      dec_data.ig_type        = exe_pkg::ig_type_e'(ctl[26:24]);
      dec_data.op.alu_op      = exe_pkg::alu_op_e'(ctl[23:20]);  // Same bits for br_op
      dec_data.sel_x          = exe_pkg::alu_sel_e'(ctl[19:18]);
      dec_data.sel_y          = exe_pkg::alu_sel_e'(ctl[17:16]);
      dec_data.rd_wr          = ctl[14];
      dec_data.rs1_rd         = ctl[13];
      dec_data.rs2_rd         = ctl[12];
      dec_data.rd_addr        = regs[20:16];
      dec_data.rs1_addr       = regs[12:8];
      dec_data.rs2_addr       = regs[4:0];
      dec_data.predicted_addr = stim[b+5];
      dec_valid               = 1'b1;
   endtask

   // Kind 3 plain, 4 held by halt first, 5 flushed after accept
   task automatic run_instr(input int b, input int kind);
      string                name;
      int                   stall;
      int                   wait_cyc;
      int                   err0;
      logic [31:0]          fl;
      exe_pkg::exe_to_mem_t held;
      name = $sformatf("%s", {stim[b+6], stim[b+7]});
      err0 = errors;
      fl   = stim[b+10];                          // Expected flag nibbles
      @(negedge clk_in);
      if (kind == 4)
         cpu_halt = 1'b1;
      drive_instr(b);
      if (kind == 4)
      begin
         repeat (3)
         begin
            #5;
            check_cond(name, "dec_rdy high while halted", !dec_rdy);
            @(negedge clk_in);
         end
         cpu_halt = 1'b0;
      end
      #5;
      // Reload is combinational, before acceptance
      check_field(name, "rld_pc_flag", 32'(fl[24]), 32'(rld_pc_flag));
      check_field(name, "rld_pc_addr", stim[b+11], rld_pc_addr);
      wait_cyc = 0;
      while (!dec_rdy && wait_cyc < 8)
      begin
         @(negedge clk_in);
         #5;
         wait_cyc++;
      end
      check_cond(name, "dec_rdy never rose", dec_rdy);
      @(negedge clk_in);                          // Accepted on the rising edge before
      check_cond(name, "mem_valid low one cycle after accept", mem_valid);
      if (kind == 5)
      begin
         dec_valid  = 1'b0;
         pipe_flush = 1'b1;
         @(negedge clk_in);
         pipe_flush = 1'b0;
         check_cond(name, "flushed record still valid", !mem_valid);
      end
      else
      begin
         dec_data.pc = ~dec_data.pc;              // Next instruction already waits upstream
         held  = mem_data;
         stall = int'($urandom % (max_stall + 1));
         repeat (stall)
         begin
            @(negedge clk_in);
            check_cond(name, "mem_data changed under back-pressure", mem_data === held);
            check_cond(name, "dec_rdy high while register full", !dec_rdy);
         end
         check_field(name, "pc", stim[b+1], mem_data.pc);
         check_field(name, "ig_type", 32'(stim[b+3][26:24]), 32'(mem_data.ig_type));
         check_field(name, "rd_addr", 32'(fl[12] ? stim[b+4][20:16] : 5'd0),
                     32'(mem_data.rd_addr));
         check_field(name, "rd_data", stim[b+8], mem_data.rd_data);
         check_field(name, "ls_addr", stim[b+9], mem_data.ls_addr);
         check_field(name, "st_data", stim[b+12], mem_data.st_data);
         check_field(name, "mispre", 32'(fl[20]), 32'(mem_data.mispre));
         check_field(name, "mis", 32'(fl[16]), 32'(mem_data.mis));
         check_field(name, "rd_wr", 32'(fl[12]), 32'(mem_data.rd_wr));
         check_field(name, "is_ld", 32'(fl[8]), 32'(mem_data.is_ld));
         check_field(name, "is_st", 32'(fl[4]), 32'(mem_data.is_st));
         check_field(name, "zero_ext", 32'(fl[2]), 32'(mem_data.zero_ext));
         check_field(name, "size", 32'(fl[1:0]), 32'(mem_data.size));
         dec_valid = 1'b0;
         mem_rdy   = 1'b1;
         @(negedge clk_in);
         mem_rdy = 1'b0;
         check_cond(name, "record still valid after it was read", !mem_valid);
      end
      tests++;
      $display("test %s %s", name, (errors == err0) ? "ok" : "failed");
   endtask

   // ----------------------------------------
   // Main sequence
   initial
   begin
      logic [31:0] seed_ret;
      int          b;
      seed_ret   = $urandom(32'h1845);
      reset      = 1'b1;
      cpu_halt   = 1'b0;
      pipe_flush = 1'b0;
      dec_valid  = 1'b0;
      mem_rdy    = 1'b0;
      dec_data   = '0;
      fwd_mem    = '0;
      fwd_wb     = '0;
      gpr        = '0;
      foreach (stim[i])
         stim[i] = '0;                            // Kind 0 ends the list
      $readmemh("tb/exe_stim.txt", stim);
      while (n_rec < max_rec && stim[n_rec*rec_w] != 0)
         n_rec++;
      limit = 8 + n_rec * (max_stall + 12) + 20;

      repeat (8) @(posedge clk_in);
      @(negedge clk_in);
      check_cond("reset", "outputs not low in reset", !mem_valid && !dec_rdy && !rld_pc_flag);
      reset = 1'b0;
      tests++;
      $display("test reset %s", (errors == 0) ? "ok" : "failed");

      for (int r = 0; r < n_rec; r++)
      begin
         b = r * rec_w;
         case (stim[b])
            1:
            begin
               @(negedge clk_in);
               gpr[stim[b+1][4:0]] = stim[b+2];
            end
            2:
            begin
               @(negedge clk_in);
               fwd_mem = '{valid: stim[b+1][20], rd_wr: stim[b+1][16],
                           rd_addr: stim[b+1][4:0], rd_data: stim[b+2]};
               fwd_wb  = '{valid: stim[b+3][20], rd_wr: stim[b+3][16],
                           rd_addr: stim[b+3][4:0], rd_data: stim[b+4]};
            end
            default: run_instr(b, int'(stim[b]));
         endcase
      end

      $display("tests %0d errors %0d", tests, errors);
      if (errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb/exe_stim.txt
// kind 1 gpr: addr value | kind 2 fwd: mem_ctl mem_data wb_ctl wb_data (ctl: valid.20 wr.16 addr)
// kind 3/4/5 instr: pc imm ctl regs pred name name rd_data ls_addr flags rld_addr st_data
1 00000001 00000014 0 0 0 0 0 0 0 0 0 0
1 00000002 fffffff0 0 0 0 0 0 0 0 0 0 0
1 00000003 00001003 0 0 0 0 0 0 0 0 0 0
1 00000004 12345678 0 0 0 0 0 0 0 0 0 0
3 00000100 00000000 00017000 00050102 0 61646420 20202020 00000004 0 00001000 0 0
3 00000104 00000000 00117000 00060102 0 73756220 20202020 00000024 0 00001000 0 0
3 00000108 00000000 00317000 00070201 0 736c7420 20202020 00000001 0 00001000 0 0
3 0000010c 00000002 00726000 00080200 0 73726120 20202020 fffffffc 0 00001000 0 0
3 00000200 00003000 000e4000 00090000 0 61756970 63202020 00003200 0 00001000 0 0
3 00000204 00000000 00017000 00000102 0 78305f77 72202020 00000004 0 00000000 0 0
2 00110001 00000100 00110001 00000200 0 0 0 0 0 0 0 0
3 00000300 00000000 00017000 000a0103 0 6677645f 6d656d20 00001103 0 00001000 0 0
2 00110004 00000055 00110001 00000200 0 0 0 0 0 0 0 0
3 00000304 00000000 00017000 000a0103 0 6677645f 77622020 00001203 0 00001000 0 0
2 00110000 0000dead 00110000 0000beef 0 0 0 0 0 0 0 0
3 00000308 00000000 00017000 000a0003 0 6677645f 78302020 00001003 0 00001000 0 0
2 00000000 00000000 00000000 00000000 0 0 0 0 0 0 0 0
3 00000400 00000040 01013000 00000101 00000404 6265715f 6d697370 0 0 01100000 00000440 0
3 00000500 00000020 41013000 00000201 00000520 626c745f 6f6b2020 0 0 00000000 0 0
3 00000600 00000100 01104000 000b0000 00000700 6a616c20 20202020 00000604 0 00001000 0 0
3 00000604 00000000 01206000 000c0300 00000000 6a616c72 5f6d6973 0 0 00010000 0 0
3 00000800 00000004 22006000 000d0100 0 6c772020 20202020 0 00000018 00001102 0 0
3 00000804 00000001 42006000 000d0100 0 6c627520 20202020 0 00000015 00001104 0 0
3 00000808 00000002 13003000 00000104 0 73682020 20202020 0 00000016 00000011 0 12345678
3 0000080c 00000001 12006000 000d0100 0 6c685f6d 69732020 0 00000015 00011101 0 0
3 00000810 00000002 23003000 00000104 0 73775f6d 69732020 0 00000016 00010012 0 12345678
4 00000900 00000000 00017000 00050102 0 68616c74 20202020 00000004 0 00001000 0 0
5 00000904 00000000 00017000 00050102 0 666c7573 68202020 00000004 0 00001000 0 0
3 00000908 00000000 00117000 00060102 0 73756220 20202020 00000024 0 00001000 0 0

//--- project.f
logic/exe_pkg.sv
logic/operand_forward.sv
logic/alu_unit.sv
logic/branch_unit.sv
logic/ls_addr_unit.sv
logic/exe_result_sel.sv
logic/exe_pipe_reg.sv
logic/execute.sv
tb/tb_execute.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator, run from the project root
rm -f sim.log
verilator --binary --timing --assert --top-module tb_execute -f project.f -o sim_exe \
   && ./obj_dir/sim_exe > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
